// File: board_pkg.sv
// ******************************
// shared constants for the board control logic
// addresses are up bus word addresses, not byte addresses
// ******************************

package board_pkg;

  // ******************************
  // up bus
  // ******************************
  localparam int UP_ADDR_WIDTH = 14;
  localparam int UP_DATA_WIDTH = 32;

  // gpio peripheral words, low word holds bits 31:0
  localparam logic [UP_ADDR_WIDTH-1:0] ADDR_GPIO_O_LO = 14'd0;
  localparam logic [UP_ADDR_WIDTH-1:0] ADDR_GPIO_O_HI = 14'd1;
  // a tristate bit at 1 makes the pin an input
  localparam logic [UP_ADDR_WIDTH-1:0] ADDR_GPIO_T_LO = 14'd2;
  localparam logic [UP_ADDR_WIDTH-1:0] ADDR_GPIO_T_HI = 14'd3;
  localparam logic [UP_ADDR_WIDTH-1:0] ADDR_GPIO_I_LO = 14'd4;
  localparam logic [UP_ADDR_WIDTH-1:0] ADDR_GPIO_I_HI = 14'd5;

  // gp bank, three output words and four input words (the last reads zero)
  localparam logic [UP_ADDR_WIDTH-1:0] ADDR_GP_OUT_BASE = 14'd8;
  localparam logic [UP_ADDR_WIDTH-1:0] ADDR_GP_IN_BASE  = 14'd12;

  // ******************************
  // widths and pin map
  // ******************************
  localparam int GPIO_WIDTH   = 64;
  localparam int GP_WIDTH     = 96;
  localparam int GP_PIN_WIDTH = 86;
  localparam int BD_PADS      = 20;
  localparam int AD_PADS      = 16;

  // radio control lines taken from the gpio outputs
  localparam int GPIO_ENABLE_BIT = 47;
  localparam int GPIO_TXNRX_BIT  = 48;

  // opcodes of the stimulus trace
  typedef enum logic [2:0] {
    OP_WRITE,
    OP_READ,
    OP_PADS,
    OP_WAIT,
    OP_END
  } trace_op_e;

endpackage

// File: gpio_pad_sync.sv
// ******************************
// split tristate pad model, no inout
// pad inputs are assumed asynchronous and get two sync flops
// ******************************

`timescale 1ns/1ps

module gpio_pad_sync #(
  parameter int WIDTH = board_pkg::BD_PADS
) (
  input  logic             up_clk,
  input  logic             rst_i,
  input  logic [WIDTH-1:0] dio_t_i,
  input  logic [WIDTH-1:0] dio_o_i,
  output logic [WIDTH-1:0] dio_i_o,
  input  logic [WIDTH-1:0] pad_i,
  output logic [WIDTH-1:0] pad_o,
  output logic [WIDTH-1:0] pad_oe_o
);

  // first and second synchronizer stages
  logic [WIDTH-1:0] pad_meta_q;
  logic [WIDTH-1:0] pad_sync_q;

  // output direction is purely combinational from the registers
  assign pad_o    = dio_o_i;
  // tristate high means input, so the driver is off
  assign pad_oe_o = ~dio_t_i;

  always_ff @(posedge up_clk) begin
    if (rst_i) begin
      pad_meta_q <= '0;
      pad_sync_q <= '0;
    end else begin
      pad_meta_q <= pad_i;
      pad_sync_q <= pad_meta_q;
    end
  end

  // like an iobuf, a driven pin reads back its own output value
  // while an input pin returns the synced pad level
  assign dio_i_o = (dio_t_i & pad_sync_q) | (~dio_t_i & dio_o_i);

endmodule

// File: up_gpio_regs.sv
// ******************************
// 64-bit gpio on the up bus, words 0 to 5
// acks and read data are one cycle after the request pulse
// tristate resets to all ones, so every pin starts as an input
// ******************************

`timescale 1ns/1ps

module up_gpio_regs (
  input  logic                                up_clk,
  input  logic                                rst_i,
  input  logic                                up_wreq_i,
  input  logic [board_pkg::UP_ADDR_WIDTH-1:0] up_waddr_i,
  input  logic [board_pkg::UP_DATA_WIDTH-1:0] up_wdata_i,
  output logic                                up_wack_o,
  input  logic                                up_rreq_i,
  input  logic [board_pkg::UP_ADDR_WIDTH-1:0] up_raddr_i,
  output logic [board_pkg::UP_DATA_WIDTH-1:0] up_rdata_o,
  output logic                                up_rack_o,
  input  logic [board_pkg::GPIO_WIDTH-1:0]    gpio_i_i,
  output logic [board_pkg::GPIO_WIDTH-1:0]    gpio_o_o,
  output logic [board_pkg::GPIO_WIDTH-1:0]    gpio_t_o
);

  import board_pkg::*;

  logic                     wsel;
  logic                     rsel;
  logic [GPIO_WIDTH-1:0]    gpio_o_q;
  logic [GPIO_WIDTH-1:0]    gpio_t_q;
  logic [UP_DATA_WIDTH-1:0] rdata_d;

  // the block owns the range from word 0 up to the input high word
  assign wsel = (up_waddr_i <= ADDR_GPIO_I_HI);
  assign rsel = (up_raddr_i <= ADDR_GPIO_I_HI);

  // ******************************
  // write side
  // ******************************

  always_ff @(posedge up_clk) begin
    if (rst_i) begin
      gpio_o_q  <= '0;
      gpio_t_q  <= '1;
      up_wack_o <= 1'b0;
    end else begin
      // input words are read only but still acknowledge a write
      up_wack_o <= up_wreq_i & wsel;
      if (up_wreq_i) begin
        case (up_waddr_i)
          ADDR_GPIO_O_LO: gpio_o_q[UP_DATA_WIDTH-1:0]          <= up_wdata_i;
          ADDR_GPIO_O_HI: gpio_o_q[GPIO_WIDTH-1:UP_DATA_WIDTH] <= up_wdata_i;
          ADDR_GPIO_T_LO: gpio_t_q[UP_DATA_WIDTH-1:0]          <= up_wdata_i;
          ADDR_GPIO_T_HI: gpio_t_q[GPIO_WIDTH-1:UP_DATA_WIDTH] <= up_wdata_i;
          default: begin
          end
        endcase
      end
    end
  end

  assign gpio_o_o = gpio_o_q;
  assign gpio_t_o = gpio_t_q;

  // ******************************
  // read side
  // ******************************

  // addresses outside the block decode to zero here
  always_comb begin
    case (up_raddr_i)
      ADDR_GPIO_O_LO: rdata_d = gpio_o_q[UP_DATA_WIDTH-1:0];
      ADDR_GPIO_O_HI: rdata_d = gpio_o_q[GPIO_WIDTH-1:UP_DATA_WIDTH];
      ADDR_GPIO_T_LO: rdata_d = gpio_t_q[UP_DATA_WIDTH-1:0];
      ADDR_GPIO_T_HI: rdata_d = gpio_t_q[GPIO_WIDTH-1:UP_DATA_WIDTH];
      ADDR_GPIO_I_LO: rdata_d = gpio_i_i[UP_DATA_WIDTH-1:0];
      ADDR_GPIO_I_HI: rdata_d = gpio_i_i[GPIO_WIDTH-1:UP_DATA_WIDTH];
      default:        rdata_d = '0;
    endcase
  end

  // read data stays zero outside the ack cycle so the top level can OR it
  always_ff @(posedge up_clk) begin
    if (rst_i) begin
      up_rack_o  <= 1'b0;
      up_rdata_o <= '0;
    end else begin
      up_rack_o  <= up_rreq_i & rsel;
      up_rdata_o <= up_rreq_i ? rdata_d : '0;
    end
  end

endmodule

// File: up_gp_regs.sv
// ******************************
// gp output bank, out words at 8 to 10, in words at 12 to 15
// in word 3 has no source and reads zero, word 11 is unmapped
// ******************************

`timescale 1ns/1ps

module up_gp_regs (
  input  logic                                up_clk,
  input  logic                                rst_i,
  input  logic                                up_wreq_i,
  input  logic [board_pkg::UP_ADDR_WIDTH-1:0] up_waddr_i,
  input  logic [board_pkg::UP_DATA_WIDTH-1:0] up_wdata_i,
  output logic                                up_wack_o,
  input  logic                                up_rreq_i,
  input  logic [board_pkg::UP_ADDR_WIDTH-1:0] up_raddr_i,
  output logic [board_pkg::UP_DATA_WIDTH-1:0] up_rdata_o,
  output logic                                up_rack_o,
  input  logic [board_pkg::GP_WIDTH-1:0]      gp_in_i,
  output logic [board_pkg::GP_WIDTH-1:0]      gp_out_o
);

  import board_pkg::*;

  // number of 32-bit words backed by real bits
  localparam int GP_WORDS = GP_WIDTH / UP_DATA_WIDTH;

  logic                     wsel_out;
  logic                     wsel_in;
  logic                     rsel_out;
  logic                     rsel_in;
  logic [1:0]               wword;
  logic [1:0]               rword_out;
  logic [1:0]               rword_in;
  logic [GP_WIDTH-1:0]      gp_out_q;
  logic [UP_DATA_WIDTH-1:0] rdata_d;

  // range decode, the input range carries one extra zero word
  assign wsel_out = (up_waddr_i >= ADDR_GP_OUT_BASE) && (up_waddr_i < ADDR_GP_OUT_BASE + GP_WORDS);
  assign wsel_in  = (up_waddr_i >= ADDR_GP_IN_BASE) && (up_waddr_i <= ADDR_GP_IN_BASE + GP_WORDS);
  assign rsel_out = (up_raddr_i >= ADDR_GP_OUT_BASE) && (up_raddr_i < ADDR_GP_OUT_BASE + GP_WORDS);
  assign rsel_in  = (up_raddr_i >= ADDR_GP_IN_BASE) && (up_raddr_i <= ADDR_GP_IN_BASE + GP_WORDS);

  // word index inside each range
  assign wword     = 2'(up_waddr_i - ADDR_GP_OUT_BASE);
  assign rword_out = 2'(up_raddr_i - ADDR_GP_OUT_BASE);
  assign rword_in  = 2'(up_raddr_i - ADDR_GP_IN_BASE);

  always_ff @(posedge up_clk) begin
    if (rst_i) begin
      gp_out_q  <= '0;
      up_wack_o <= 1'b0;
    end else begin
      up_wack_o <= up_wreq_i & (wsel_out | wsel_in);
      if (up_wreq_i && wsel_out) begin
        gp_out_q[wword*UP_DATA_WIDTH +: UP_DATA_WIDTH] <= up_wdata_i;
      end
    end
  end

  assign gp_out_o = gp_out_q;

  // out words read back the register, in words read the merged inputs
  always_comb begin
    rdata_d = '0;
    if (rsel_out) begin
      rdata_d = gp_out_q[rword_out*UP_DATA_WIDTH +: UP_DATA_WIDTH];
    end else if (rsel_in && (rword_in < 2'(GP_WORDS))) begin
      rdata_d = gp_in_i[rword_in*UP_DATA_WIDTH +: UP_DATA_WIDTH];
    end
  end

  always_ff @(posedge up_clk) begin
    if (rst_i) begin
      up_rack_o  <= 1'b0;
      up_rdata_o <= '0;
    end else begin
      up_rack_o  <= up_rreq_i & (rsel_out | rsel_in);
      up_rdata_o <= up_rreq_i ? rdata_d : '0;
    end
  end

endmodule

// File: system_top.sv
// ******************************
// board control top, tristate pads split into i/o/oe ports
// DDR, LVDS data path, SPI, I2C and transceivers are not modeled
// ******************************

`timescale 1ns/1ps

module system_top (
  input  logic                                 up_clk,
  input  logic                                 rst_i,
  input  logic                                 up_wreq_i,
  input  logic [board_pkg::UP_ADDR_WIDTH-1:0]  up_waddr_i,
  input  logic [board_pkg::UP_DATA_WIDTH-1:0]  up_wdata_i,
  output logic                                 up_wack_o,
  input  logic                                 up_rreq_i,
  input  logic [board_pkg::UP_ADDR_WIDTH-1:0]  up_raddr_i,
  output logic [board_pkg::UP_DATA_WIDTH-1:0]  up_rdata_o,
  output logic                                 up_rack_o,
  input  logic [board_pkg::BD_PADS-1:0]        gpio_bd_i,
  output logic [board_pkg::BD_PADS-1:0]        gpio_bd_o,
  output logic [board_pkg::BD_PADS-1:0]        gpio_bd_oe_o,
  input  logic [board_pkg::AD_PADS-1:0]        gpio_ad_i,
  output logic [board_pkg::AD_PADS-1:0]        gpio_ad_o,
  output logic [board_pkg::AD_PADS-1:0]        gpio_ad_oe_o,
  input  logic [board_pkg::GP_PIN_WIDTH-1:0]   gp_in_i,
  output logic [board_pkg::GP_PIN_WIDTH-1:0]   gp_out_o,
  output logic                                 enable_o,
  output logic                                 txnrx_o,
  input  logic                                 clkout_in_i,
  output logic                                 clkout_out_o
);

  import board_pkg::*;

  logic [GPIO_WIDTH-1:0]    gpio_i;
  logic [GPIO_WIDTH-1:0]    gpio_o;
  logic [GPIO_WIDTH-1:0]    gpio_t;
  logic [GP_WIDTH-1:0]      gp_in_s;
  logic [GP_WIDTH-1:0]      gp_out_s;
  logic                     gpio_wack;
  logic                     gpio_rack;
  logic [UP_DATA_WIDTH-1:0] gpio_rdata;
  logic                     gp_wack;
  logic                     gp_rack;
  logic [UP_DATA_WIDTH-1:0] gp_rdata;

  // both blocks zero their read data when idle, so a plain OR merges them
  assign up_wack_o  = gpio_wack | gp_wack;
  assign up_rack_o  = gpio_rack | gp_rack;
  assign up_rdata_o = gpio_rdata | gp_rdata;

  assign clkout_out_o = clkout_in_i;

  // radio control lines come straight from the gpio outputs
  assign enable_o = gpio_o[GPIO_ENABLE_BIT];
  assign txnrx_o  = gpio_o[GPIO_TXNRX_BIT];

  // ******************************
  // gp bank with internal loopback
  // ******************************

  // the top 10 gp bits have no pins and loop back into the input words
  assign gp_out_o = gp_out_s[GP_PIN_WIDTH-1:0];
  assign gp_in_s  = {gp_out_s[GP_WIDTH-1:GP_PIN_WIDTH], gp_in_i};

  up_gp_regs i_gp_regs (
    .up_clk     (up_clk),
    .rst_i      (rst_i),
    .up_wreq_i  (up_wreq_i),
    .up_waddr_i (up_waddr_i),
    .up_wdata_i (up_wdata_i),
    .up_wack_o  (gp_wack),
    .up_rreq_i  (up_rreq_i),
    .up_raddr_i (up_raddr_i),
    .up_rdata_o (gp_rdata),
    .up_rack_o  (gp_rack),
    .gp_in_i    (gp_in_s),
    .gp_out_o   (gp_out_s)
  );

  // ******************************
  // gpio and pin map
  // ******************************

  up_gpio_regs i_gpio_regs (
    .up_clk     (up_clk),
    .rst_i      (rst_i),
    .up_wreq_i  (up_wreq_i),
    .up_waddr_i (up_waddr_i),
    .up_wdata_i (up_wdata_i),
    .up_wack_o  (gpio_wack),
    .up_rreq_i  (up_rreq_i),
    .up_raddr_i (up_raddr_i),
    .up_rdata_o (gpio_rdata),
    .up_rack_o  (gpio_rack),
    .gpio_i_i   (gpio_i),
    .gpio_o_o   (gpio_o),
    .gpio_t_o   (gpio_t)
  );

  // unpadded bits read back their own output
  assign gpio_i[31:20] = gpio_o[31:20];
  assign gpio_i[50:47] = gpio_o[50:47];
  assign gpio_i[63:52] = gpio_o[63:52];

  // board pads on bits 19:0
  gpio_pad_sync #(.WIDTH(BD_PADS)) i_sync_bd (
    .up_clk   (up_clk),
    .rst_i    (rst_i),
    .dio_t_i  (gpio_t[BD_PADS-1:0]),
    .dio_o_i  (gpio_o[BD_PADS-1:0]),
    .dio_i_o  (gpio_i[BD_PADS-1:0]),
    .pad_i    (gpio_bd_i),
    .pad_o    (gpio_bd_o),
    .pad_oe_o (gpio_bd_oe_o)
  );

  // radio pads, msb first: clksel 51, resetb 46, sync 45, en_agc 44,
  // ctl 43:40, status 39:32
  gpio_pad_sync #(.WIDTH(AD_PADS)) i_sync_ad (
    .up_clk   (up_clk),
    .rst_i    (rst_i),
    .dio_t_i  ({gpio_t[51], gpio_t[46:32]}),
    .dio_o_i  ({gpio_o[51], gpio_o[46:32]}),
    .dio_i_o  ({gpio_i[51], gpio_i[46:32]}),
    .pad_i    (gpio_ad_i),
    .pad_o    (gpio_ad_o),
    .pad_oe_o (gpio_ad_oe_o)
  );

endmodule

// File: tb_system_top.sv
// ******************************
// runs the up bus operations of system_top_trace.txt line by line
// a wait of 0 cycles checks at the sample point left by the previous bus op
// ******************************

`timescale 1ns/1ps

module tb_system_top;

  import board_pkg::*;

  localparam string TRACE_FILE = "system_top_trace.txt";
  localparam int    CLK_HALF   = 20;

  logic                     up_clk;
  logic                     rst_i;
  logic                     up_wreq_i;
  logic [UP_ADDR_WIDTH-1:0] up_waddr_i;
  logic [UP_DATA_WIDTH-1:0] up_wdata_i;
  logic                     up_wack_o;
  logic                     up_rreq_i;
  logic [UP_ADDR_WIDTH-1:0] up_raddr_i;
  logic [UP_DATA_WIDTH-1:0] up_rdata_o;
  logic                     up_rack_o;
  logic [BD_PADS-1:0]       gpio_bd_i;
  logic [BD_PADS-1:0]       gpio_bd_o;
  logic [BD_PADS-1:0]       gpio_bd_oe_o;
  logic [AD_PADS-1:0]       gpio_ad_i;
  logic [AD_PADS-1:0]       gpio_ad_o;
  logic [AD_PADS-1:0]       gpio_ad_oe_o;
  logic [GP_PIN_WIDTH-1:0]  gp_in_i;
  logic [GP_PIN_WIDTH-1:0]  gp_out_o;
  logic                     enable_o;
  logic                     txnrx_o;
  logic                     clkout_in_i;
  logic                     clkout_out_o;

  // the trace holds one entry per operation line
  trace_op_e   op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [31:0] exp_q[$];

  int err_cnt       = 0;
  int check_cnt     = 0;
  int test_cnt      = 0;
  int test_err_base = 0;
  int cycle_cnt     = 0;
  int timeout_limit = 0;
  bit load_ok;

  system_top dut (.*);

  initial begin
    up_clk = 1'b0;
    forever #CLK_HALF up_clk = ~up_clk;
  end

  // the limit stays 0 until the trace is read, which holds the counter back
  initial begin
    wait (timeout_limit > 0);
    while (cycle_cnt < timeout_limit) begin
      @(posedge up_clk);
      cycle_cnt++;
    end
    $display("run timed out after %0d cycles before the trace was done", cycle_cnt);
    $display("Testbench failed");
    $finish;
  end

  // ******************************
  // trace loading
  // ******************************

  function automatic bit parse_opcode(input logic [95:0] tok, output trace_op_e op);
    parse_opcode = 1'b1;
    op = OP_END;
    case (tok)
      "OP_WRITE": op = OP_WRITE;
      "OP_READ":  op = OP_READ;
      "OP_PADS":  op = OP_PADS;
      "OP_WAIT":  op = OP_WAIT;
      "OP_END":   op = OP_END;
      default:    parse_opcode = 1'b0;
    endcase
  endfunction

  task automatic load_trace(output bit ok);
    int               fd;
    int               n;
    int               line_no;
    logic [8*160-1:0] line_buf;
    logic [95:0]      tok;
    logic [31:0]      a_val;
    logic [31:0]      d_val;
    logic [31:0]      e_val;
    trace_op_e        op;
    ok = 1'b1;
    line_no = 0;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the trace file %s", TRACE_FILE);
      ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        line_buf = '0;
        if ($fgets(line_buf, fd) != 0) begin
          line_no++;
          tok = '0;
          n = $sscanf(line_buf, "%s %h %h %h", tok, a_val, d_val, e_val);
          // blank lines and lines that open with a lone hash are skipped
          if (n <= 0 || tok == "#") begin
          end else if (n != 4 || !parse_opcode(tok, op)) begin
            $display("trace line %0d cannot be parsed", line_no);
            ok = 1'b0;
          end else begin
            op_q.push_back(op);
            addr_q.push_back(a_val);
            data_q.push_back(d_val);
            exp_q.push_back(e_val);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ******************************
  // checks
  // ******************************

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s, got 0x%h, expected 0x%h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_ack(input string kind, input logic [31:0] addr,
                           input bit acked, input bit ack_exp);
    check_cnt++;
    if (ack_exp) begin
      assert (acked) else begin
        $display("no acknowledge for the %s of address 0x%h at %0t ns", kind, addr, $time);
        err_cnt++;
      end
    end else begin
      assert (!acked) else begin
        $display("unexpected acknowledge for the %s of address 0x%h at %0t ns",
                 kind, addr, $time);
        err_cnt++;
      end
      if (!acked) begin
        $display("%s of address 0x%h: no acknowledge", kind, addr);
      end
    end
  endtask

  // observable outputs packed into 32-bit groups the trace can name
  function automatic logic [31:0] output_group(input logic [31:0] sel);
    case (sel)
      1:       output_group = 32'(gpio_bd_o);
      2:       output_group = 32'(gpio_bd_oe_o);
      3:       output_group = 32'(gpio_ad_o);
      4:       output_group = 32'(gpio_ad_oe_o);
      5:       output_group = {30'b0, txnrx_o, enable_o};
      6:       output_group = gp_out_o[31:0];
      7:       output_group = gp_out_o[63:32];
      8:       output_group = 32'(gp_out_o[GP_PIN_WIDTH-1:64]);
      default: output_group = 'x;
    endcase
  endfunction

  // clkout passes straight through, so each level shows up by the next falling edge
  task automatic check_clkout();
    for (int lvl = 1; lvl >= 0; lvl--) begin
      @(posedge up_clk);
      clkout_in_i <= 1'(lvl);
      @(negedge up_clk);
      check_value("clock-out pass-through", 32'(clkout_out_o), 32'(lvl));
    end
  endtask

  // ******************************
  // bus and pin operations
  // ******************************

  // the ack is a one-cycle pulse, so each falling edge is a sample point
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data, input bit ack_exp);
    bit acked;
    acked = 1'b0;
    @(posedge up_clk);
    up_wreq_i  <= 1'b1;
    up_waddr_i <= addr[UP_ADDR_WIDTH-1:0];
    up_wdata_i <= data;
    @(posedge up_clk);
    up_wreq_i <= 1'b0;
    for (int i = 0; i < 2 && !acked; i++) begin
      @(negedge up_clk);
      acked = up_wack_o;
    end
    check_ack("write", addr, acked, ack_exp);
  endtask

  task automatic bus_read(input logic [31:0] addr, input bit ack_exp, input logic [31:0] exp);
    bit          acked;
    logic [31:0] rdata;
    acked = 1'b0;
    rdata = '0;
    @(posedge up_clk);
    up_rreq_i  <= 1'b1;
    up_raddr_i <= addr[UP_ADDR_WIDTH-1:0];
    @(posedge up_clk);
    up_rreq_i <= 1'b0;
    for (int i = 0; i < 2 && !acked; i++) begin
      @(negedge up_clk);
      acked = up_rack_o;
      // data seen anywhere in the window counts, even without an ack
      rdata = rdata | up_rdata_o;
    end
    check_ack("read", addr, acked, ack_exp);
    check_value($sformatf("read of address 0x%h", addr), rdata, exp);
  endtask

  task automatic drive_pads(input logic [31:0] sel, input logic [31:0] data);
    @(posedge up_clk);
    case (sel)
      0: gpio_bd_i <= data[BD_PADS-1:0];
      1: gpio_ad_i <= data[AD_PADS-1:0];
      2: gp_in_i[31:0] <= data;
      3: gp_in_i[63:32] <= data;
      4: gp_in_i[GP_PIN_WIDTH-1:64] <= data[GP_PIN_WIDTH-65:0];
      default: begin
        $display("trace selects an unknown pad group %0d", sel);
        err_cnt++;
      end
    endcase
  endtask

  task automatic idle_and_check(input logic [31:0] n, input logic [31:0] sel,
                                input logic [31:0] exp);
    if (n > 0) begin
      repeat (n) @(posedge up_clk);
      @(negedge up_clk);
    end
    if (sel != 0) begin
      check_value($sformatf("output group %0d", sel), output_group(sel), exp);
    end
  endtask

  // ******************************
  // main sequence
  // ******************************

  initial begin
    rst_i       = 1'b1;
    up_wreq_i   = 1'b0;
    up_waddr_i  = '0;
    up_wdata_i  = '0;
    up_rreq_i   = 1'b0;
    up_raddr_i  = '0;
    gpio_bd_i   = '0;
    gpio_ad_i   = '0;
    gp_in_i     = '0;
    clkout_in_i = 1'b0;
    load_trace(load_ok);
    if (!load_ok) begin
      $display("the trace could not be loaded");
      $display("Testbench failed");
      $finish;
    end else begin
      timeout_limit = op_q.size() * 8;
      repeat (2) @(posedge up_clk);
      rst_i <= 1'b0;
      check_clkout();
      foreach (op_q[i]) begin
        case (op_q[i])
          OP_WRITE: bus_write(addr_q[i], data_q[i], exp_q[i][0]);
          OP_READ:  bus_read(addr_q[i], data_q[i][0], exp_q[i]);
          OP_PADS:  drive_pads(addr_q[i], data_q[i]);
          OP_WAIT:  idle_and_check(addr_q[i], data_q[i], exp_q[i]);
          default: begin
            test_cnt++;
            $display("test %0d done with %0d errors", addr_q[i], err_cnt - test_err_base);
            test_err_base = err_cnt;
          end
        endcase
      end
      $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

endmodule

// File: sources.f
board_pkg.sv
gpio_pad_sync.sv
up_gpio_regs.sv
up_gp_regs.sv
system_top.sv
tb_system_top.sv

// File: Bender.yml
package:
  name: system_top

sources:
  - board_pkg.sv
  - gpio_pad_sync.sv
  - up_gpio_regs.sv
  - up_gp_regs.sv
  - system_top.sv
  - target: test
    files:
      - tb_system_top.sv

// File: system_top_trace.txt
# columns: opcode, address, data, expected value, all numbers in hex
# write: data is written and expected is 1 when an ack is due
# read: data is 1 when an ack is due and expected is the read value
# pads: address 0 board pads, 1 radio pads, 2 to 4 gp_in words
# wait: address is a cycle count and data is an output group (0 none) checked against expected
# groups: 1 bd_o, 2 bd_oe, 3 ad_o, 4 ad_oe, 5 {txnrx, enable}, 6 to 8 gp_out words
# end: address is the number of the finished test
OP_WAIT  1   2        0
OP_WAIT  0   4        0
OP_WAIT  0   5        0
OP_WAIT  0   6        0
OP_READ  2   1        FFFFFFFF
OP_READ  3   1        FFFFFFFF
OP_READ  0   1        0
OP_READ  1   1        0
OP_READ  8   1        0
OP_READ  a   1        0
OP_END   1   0        0
OP_WRITE 0   12345A5A 1
OP_WAIT  0   1        45A5A
OP_WRITE 1   C3A90F0F 1
OP_WAIT  0   5        2
OP_WRITE 2   FFF0F0F0 1
OP_WAIT  0   2        F0F0F
OP_WRITE 3   FFFF00FF 1
OP_WAIT  0   3        8F0F
OP_WAIT  0   4        7F00
OP_READ  1   1        C3A90F0F
OP_END   2   0        0
OP_PADS  0   ABCDE    0
OP_PADS  1   1234     0
OP_WAIT  3   0        0
OP_READ  4   1        1234BADA
OP_READ  5   1        C3A10F34
OP_END   3   0        0
OP_WRITE 8   DEADBEEF 1
OP_WRITE 9   01234567 1
OP_WRITE a   A5C01ABC 1
OP_WAIT  0   6        DEADBEEF
OP_WAIT  0   7        01234567
OP_WAIT  0   8        1ABC
OP_PADS  2   11112222 0
OP_PADS  3   33334444 0
OP_PADS  4   255AA5   0
OP_WAIT  1   0        0
OP_READ  a   1        A5C01ABC
OP_READ  c   1        11112222
OP_READ  d   1        33334444
OP_READ  e   1        A5E55AA5
OP_READ  f   1        0
OP_END   4   0        0
OP_READ  b   0        0
OP_READ  100 0        0
OP_WRITE 7   FFFFFFFF 0
OP_READ  0   1        12345A5A
OP_END   5   0        0
